// File: common/sample_pkg.sv
// shared widths, configuration and packet-info structs, beat tag and capture states
`default_nettype none

package sample_pkg;

    // byte address in capture memory
    typedef logic [63:0] addr_t;
    // sample or byte count
    typedef logic [31:0] count_t;

    // active capture configuration
    typedef struct packed {
        addr_t  start_addr;
        addr_t  end_addr;
        count_t sample_num;
        count_t pre_sample_num;
    } capture_cfg_t;

    // one packet record, address in the upper bits
    typedef struct packed {
        addr_t  addr;
        count_t length;
    } pkt_info_t;

    // sideband carried with every beat
    typedef struct packed {
        logic trig;
        logic last_sample;
    } beat_tag_t;

    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        PRE,
        WAIT,
        POST,
        DONE,
        ERR
    } capture_state_e;

    // configuration after reset
    localparam count_t DEFAULT_SAMPLE_NUM = 32'd1024;
    localparam count_t DEFAULT_PRE_NUM    = 32'd512;
    localparam addr_t  DEFAULT_START_ADDR = 64'h0000_0000_0000_0000;
    localparam addr_t  DEFAULT_END_ADDR   = 64'h0000_0000_FFFF_FFFF;

endpackage

`default_nettype wire

// File: hdl/sample_config.sv
// capture configuration register with pairwise consistency checks
`timescale 1ns/1ps
`default_nettype none

module sample_config (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire sample_pkg::addr_t     config_start_addr,
    input  wire sample_pkg::addr_t     config_end_addr,
    input  wire sample_pkg::count_t    config_sample_num,
    input  wire sample_pkg::count_t    config_pre_sample_num,
    input  wire                        update_config,
    output sample_pkg::capture_cfg_t   cfg
);

    import sample_pkg::*;

    logic samples_ok;
    logic addrs_ok;

    // each pair stands or falls on its own
    assign samples_ok = (config_pre_sample_num <= config_sample_num);
    assign addrs_ok   = (config_start_addr < config_end_addr);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg.start_addr     <= DEFAULT_START_ADDR;
            cfg.end_addr       <= DEFAULT_END_ADDR;
            cfg.sample_num     <= DEFAULT_SAMPLE_NUM;
            cfg.pre_sample_num <= DEFAULT_PRE_NUM;
        end else if (update_config) begin
            if (samples_ok) begin
                cfg.sample_num     <= config_sample_num;
                cfg.pre_sample_num <= config_pre_sample_num;
            end
            if (addrs_ok) begin
                cfg.start_addr <= config_start_addr;
                cfg.end_addr   <= config_end_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: capture/capture_fsm.sv
// capture FSM with beat counting, trigger and final-beat tagging, status pulses
`timescale 1ns/1ps
`default_nettype none

module capture_fsm #(
    parameter int BIT_WIDTH = 64
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire sample_pkg::capture_cfg_t cfg,
    input  wire                           sample_start,
    input  wire                           sample_trig,
    input  wire                           data_valid,
    input  wire                           beat_accept,
    input  wire sample_pkg::beat_tag_t    accept_tag,
    output logic                          load,
    output sample_pkg::beat_tag_t         load_tag,
    output logic                          sample_busy,
    output logic                          sample_done,
    output logic                          sample_err,
    output logic                          trig_out
);

    import sample_pkg::*;

    localparam addr_t BEAT_BYTES = addr_t'(BIT_WIDTH / 8);

    capture_state_e state;
    capture_state_e next_state;
    count_t         load_cnt;
    count_t         post_left;
    count_t         trig_pos;
    count_t         post_total;
    addr_t          window_end;
    logic           cfg_bad;
    logic           trig_hit;
    logic           final_accept;

    // ********************
    // settings check

    assign window_end = cfg.start_addr + addr_t'(cfg.sample_num) * BEAT_BYTES;
    assign cfg_bad    = (cfg.sample_num == '0) ||
                        (cfg.pre_sample_num > cfg.sample_num) ||
                        (window_end > cfg.end_addr);

    // trigger counts as beat 1 when there is no pre-trigger window
    assign trig_pos   = (cfg.pre_sample_num == '0) ? count_t'(1) : cfg.pre_sample_num;
    assign post_total = cfg.sample_num - trig_pos;

    // ********************
    // beat loading and tagging

    assign trig_hit = data_valid && sample_trig &&
                      (((state == PRE) && (load_cnt + count_t'(1) >= cfg.pre_sample_num)) ||
                       (state == WAIT));

    always_comb begin
        load                 = 1'b0;
        load_tag.trig        = trig_hit;
        load_tag.last_sample = 1'b0;
        case (state)
            PRE: begin
                load                 = data_valid;
                load_tag.last_sample = trig_hit && (post_total == '0);
            end
            WAIT: begin
                // nothing goes out before the trigger here
                load                 = trig_hit;
                load_tag.last_sample = post_total == '0;
            end
            POST: begin
                load                 = data_valid && (post_left != '0);
                load_tag.last_sample = post_left == count_t'(1);
            end
            default: begin
                load = 1'b0;
            end
        endcase
    end

    assign final_accept = (state == POST) && beat_accept && accept_tag.last_sample;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (sample_start) next_state = CHECK;
            CHECK: begin
                if (cfg_bad) begin
                    next_state = ERR;
                end else if (cfg.pre_sample_num == '0) begin
                    next_state = WAIT;
                end else begin
                    next_state = PRE;
                end
            end
            PRE, WAIT: if (trig_hit) next_state = POST;
            POST:    if (final_accept) next_state = DONE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= IDLE;
            load_cnt    <= '0;
            post_left   <= '0;
            sample_busy <= 1'b0;
            sample_done <= 1'b0;
            sample_err  <= 1'b0;
            trig_out    <= 1'b0;
        end else begin
            state       <= next_state;
            sample_busy <= (next_state != IDLE);
            sample_done <= final_accept;
            sample_err  <= (state == CHECK) && cfg_bad;
            trig_out    <= trig_hit;
            if (state == CHECK) begin
                load_cnt <= '0;
            end else if (load) begin
                load_cnt <= load_cnt + count_t'(1);
            end
            // beats still to come after the trigger beat
            if (trig_hit) begin
                post_left <= post_total;
            end else if ((state == POST) && load) begin
                post_left <= post_left - count_t'(1);
            end
        end
    end

    // done comes from POST and err from CHECK, never the same cycle
    assert property (@(posedge clk) disable iff (!rstn) !(sample_done && sample_err));
    assert property (@(posedge clk) disable iff (!rstn) (state == IDLE) |-> !load);

endmodule

`default_nettype wire

// File: capture/beat_register.sv
// one-deep stream output register for a data beat and its tag
`timescale 1ns/1ps
`default_nettype none

module beat_register #(
    parameter int BIT_WIDTH = 64
) (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        load,
    input  wire sample_pkg::beat_tag_t load_tag,
    input  wire [BIT_WIDTH-1:0]        data,
    input  wire                        m_axis_tready,
    output logic                       m_axis_tvalid,
    output logic [BIT_WIDTH-1:0]       m_axis_tdata,
    output logic                       beat_accept,
    output sample_pkg::beat_tag_t      accept_tag
);

    assign beat_accept = m_axis_tvalid && m_axis_tready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            m_axis_tvalid <= 1'b0;
            accept_tag    <= '0;
        end else if (load) begin
            // a held beat gets overwritten, so samples are lost
            m_axis_tvalid <= 1'b1;
            accept_tag    <= load_tag;
        end else if (beat_accept) begin
            m_axis_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_axis_tdata <= data;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid);

endmodule

`default_nettype wire

// File: packer/block_packer.sv
// ring address, block byte count, tlast generation and packet-info writes
`timescale 1ns/1ps
`default_nettype none

module block_packer #(
    parameter int BIT_WIDTH  = 64,
    parameter int BLOCK_SIZE = 512
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire sample_pkg::capture_cfg_t cfg,
    input  wire                           sample_start,
    input  wire                           beat_accept,
    input  wire sample_pkg::beat_tag_t    accept_tag,
    output logic                          m_axis_tlast,
    output logic                          pkt_info_wr,
    output sample_pkg::pkt_info_t         pkt_info_data,
    output sample_pkg::addr_t             beat_addr
);

    import sample_pkg::*;

    localparam count_t BEAT_BYTES = count_t'(BIT_WIDTH / 8);

    addr_t  block_addr;
    addr_t  next_addr;
    count_t byte_cnt;
    count_t next_cnt;
    logic   block_full;
    logic   no_space;
    logic   push;

    assign next_cnt  = byte_cnt + BEAT_BYTES;
    assign next_addr = beat_addr + addr_t'(BEAT_BYTES);

    // ********************
    // packet end conditions of the held beat

    assign block_full   = (next_cnt == count_t'(BLOCK_SIZE));
    assign no_space     = (next_addr >= cfg.end_addr);
    assign m_axis_tlast = block_full || no_space || accept_tag.last_sample;
    assign push         = beat_accept && m_axis_tlast;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_addr  <= '0;
            block_addr <= '0;
            byte_cnt   <= '0;
        end else if (sample_start) begin
            beat_addr  <= cfg.start_addr;
            block_addr <= cfg.start_addr;
            byte_cnt   <= '0;
        end else if (beat_accept) begin
            // wrap to ring start once a beat reaches the end
            beat_addr <= no_space ? cfg.start_addr : next_addr;
            byte_cnt  <= push ? '0 : next_cnt;
            if (push) begin
                block_addr <= no_space ? cfg.start_addr : next_addr;
            end
        end
    end

    // ********************
    // packet info record

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pkt_info_wr <= 1'b0;
        end else begin
            pkt_info_wr <= push;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pkt_info_data.addr   <= block_addr;
            pkt_info_data.length <= next_cnt;
        end
    end

endmodule

`default_nettype wire

// File: packer/record_tracker.sv
// trigger, end and start address records of the captured window
`timescale 1ns/1ps
`default_nettype none

module record_tracker #(
    parameter int BIT_WIDTH = 64
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire sample_pkg::capture_cfg_t cfg,
    input  wire                           beat_accept,
    input  wire sample_pkg::beat_tag_t    accept_tag,
    input  wire sample_pkg::addr_t        beat_addr,
    output sample_pkg::addr_t             rec_trig_addr,
    output sample_pkg::addr_t             rec_start_addr,
    output sample_pkg::addr_t             rec_end_addr
);

    import sample_pkg::*;

    localparam addr_t BEAT_BYTES = addr_t'(BIT_WIDTH / 8);

    addr_t span;
    addr_t ring_size;
    addr_t offset;
    addr_t window_start;

    // distance from first to final beat of the window
    assign span      = addr_t'(cfg.sample_num - count_t'(1)) * BEAT_BYTES;
    // addresses assumed beat aligned
    assign ring_size = cfg.end_addr - cfg.start_addr;
    assign offset    = beat_addr - cfg.start_addr;

    // step back from the final beat, wrapping into the ring
    assign window_start = (offset >= span) ? (beat_addr - span)
                                           : (beat_addr + ring_size - span);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rec_trig_addr  <= '0;
            rec_start_addr <= '0;
            rec_end_addr   <= '0;
        end else if (beat_accept) begin
            if (accept_tag.trig) begin
                rec_trig_addr <= beat_addr;
            end
            if (accept_tag.last_sample) begin
                rec_end_addr   <= beat_addr;
                rec_start_addr <= window_start;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sample_core.sv
// top level of the capture core: config, capture FSM, output register, packer, records
`timescale 1ns/1ps
`default_nettype none

module sample_core #(
    parameter int BIT_WIDTH  = 64,
    parameter int BLOCK_SIZE = 512
) (
    input  wire                        clk,
    input  wire                        rstn,
    // configuration
    input  wire sample_pkg::addr_t     config_start_addr,
    input  wire sample_pkg::addr_t     config_end_addr,
    input  wire sample_pkg::count_t    config_sample_num,
    input  wire sample_pkg::count_t    config_pre_sample_num,
    input  wire                        update_config,
    // capture control
    input  wire                        sample_start,
    input  wire                        sample_trig,
    input  wire [BIT_WIDTH-1:0]        data,
    input  wire                        data_valid,
    // status
    output wire                        sample_busy,
    output wire                        sample_done,
    output wire                        sample_err,
    output wire                        trig_out,
    // stream master
    output wire                        m_axis_tvalid,
    output wire [BIT_WIDTH-1:0]        m_axis_tdata,
    output wire                        m_axis_tlast,
    input  wire                        m_axis_tready,
    // packet info
    output wire                        pkt_info_wr,
    output wire sample_pkg::pkt_info_t pkt_info_data,
    // window records
    output wire sample_pkg::addr_t     rec_trig_addr,
    output wire sample_pkg::addr_t     rec_start_addr,
    output wire sample_pkg::addr_t     rec_end_addr
);

    import sample_pkg::*;

    capture_cfg_t cfg;
    logic         load;
    beat_tag_t    load_tag;
    logic         beat_accept;
    beat_tag_t    accept_tag;
    addr_t        beat_addr;

    // ********************
    // configuration and capture control

    sample_config u_config (
        .clk                   (clk),
        .rstn                  (rstn),
        .config_start_addr     (config_start_addr),
        .config_end_addr       (config_end_addr),
        .config_sample_num     (config_sample_num),
        .config_pre_sample_num (config_pre_sample_num),
        .update_config         (update_config),
        .cfg                   (cfg)
    );

    capture_fsm #(
        .BIT_WIDTH (BIT_WIDTH)
    ) u_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .cfg          (cfg),
        .sample_start (sample_start),
        .sample_trig  (sample_trig),
        .data_valid   (data_valid),
        .beat_accept  (beat_accept),
        .accept_tag   (accept_tag),
        .load         (load),
        .load_tag     (load_tag),
        .sample_busy  (sample_busy),
        .sample_done  (sample_done),
        .sample_err   (sample_err),
        .trig_out     (trig_out)
    );

    beat_register #(
        .BIT_WIDTH (BIT_WIDTH)
    ) u_beat (
        .clk           (clk),
        .rstn          (rstn),
        .load          (load),
        .load_tag      (load_tag),
        .data          (data),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .beat_accept   (beat_accept),
        .accept_tag    (accept_tag)
    );

    // ********************
    // ring packing and records

    block_packer #(
        .BIT_WIDTH  (BIT_WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_packer (
        .clk           (clk),
        .rstn          (rstn),
        .cfg           (cfg),
        .sample_start  (sample_start),
        .beat_accept   (beat_accept),
        .accept_tag    (accept_tag),
        .m_axis_tlast  (m_axis_tlast),
        .pkt_info_wr   (pkt_info_wr),
        .pkt_info_data (pkt_info_data),
        .beat_addr     (beat_addr)
    );

    record_tracker #(
        .BIT_WIDTH (BIT_WIDTH)
    ) u_records (
        .clk            (clk),
        .rstn           (rstn),
        .cfg            (cfg),
        .beat_accept    (beat_accept),
        .accept_tag     (accept_tag),
        .beat_addr      (beat_addr),
        .rec_trig_addr  (rec_trig_addr),
        .rec_start_addr (rec_start_addr),
        .rec_end_addr   (rec_end_addr)
    );

endmodule

`default_nettype wire

// File: verification/tb_tasks.svh
// check, random generator, drive and collect tasks, directed tests of the capture core
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic report_fail(string msg);
    fail_count++;
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
endtask

task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
        report_fail($sformatf("ERROR %s expected %0h actual %0h", name, expected, actual));
    end
endtask

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

task automatic build_stim(int n, int trig_at);
    stim_data.delete();
    stim_trig.delete();
    for (int i = 0; i < n; i++) begin
        stim_data.push_back({lcg_next(), lcg_next()});
        stim_trig.push_back(i == trig_at);
    end
endtask

// drive one update strobe and mirror the pairwise accept rules
task automatic apply_config(logic [63:0] s, logic [63:0] e, int num, int pre);
    config_start_addr = s;
    config_end_addr = e;
    config_sample_num = count_t'(num);
    config_pre_sample_num = count_t'(pre);
    update_config = 1'b1;
    @(posedge clk);
    #1;
    update_config = 1'b0;
    if (pre <= num) begin
        m_sample = num;
        m_pre = pre;
    end
    if (s < e) begin
        m_start = s;
        m_end = e;
    end
endtask

task automatic prepare(int n, int trig_at);
    build_stim(n, trig_at);
    predict();
    got_data.delete();
    got_last.delete();
    got_pkt_addr.delete();
    got_pkt_len.delete();
    done_base = done_cnt;
    trig_base = trig_cnt;
endtask

// returns two cycles after the strobe with the FSM past CHECK
task automatic start_capture();
    sample_start = 1'b1;
    @(posedge clk);
    #1;
    sample_start = 1'b0;
    @(posedge clk);
    #1;
endtask

task automatic drive_range(int lo, int hi);
    for (int i = lo; i <= hi; i++) begin
        data_valid = 1'b1;
        data = stim_data[i];
        sample_trig = stim_trig[i];
        @(posedge clk);
        #1;
    end
    data_valid = 1'b0;
    sample_trig = 1'b0;
endtask

task automatic check_records(string name);
    check({name, " rec_trig_addr"}, exp_trig_addr, rec_trig_addr);
    check({name, " rec_end_addr"}, exp_end_addr, rec_end_addr);
    check({name, " rec_start_addr"}, exp_start_addr, rec_start_addr);
endtask

task automatic finish_capture(string name);
    int waited;
    waited = 0;
    while (done_cnt == done_base) begin
        @(posedge clk);
        #1;
        waited++;
        if (waited > DONE_LIMIT) begin
            report_fail({name, ": sample_done never came"});
        end
    end
    check({name, " busy after done"}, 64'(0), 64'(sample_busy));
    check({name, " beat count"}, 64'(exp_data.size()), 64'(got_data.size()));
    foreach (exp_data[i]) begin
        check($sformatf("%s tdata %0d", name, i), exp_data[i], got_data[i]);
        check($sformatf("%s tlast %0d", name, i), 64'(exp_last[i]), 64'(got_last[i]));
    end
    check({name, " packet count"}, 64'(exp_pkt_addr.size()), 64'(got_pkt_addr.size()));
    foreach (exp_pkt_addr[i]) begin
        check($sformatf("%s pkt addr %0d", name, i), exp_pkt_addr[i], got_pkt_addr[i]);
        check($sformatf("%s pkt len %0d", name, i), exp_pkt_len[i], got_pkt_len[i]);
    end
    check({name, " trig_out pulses"}, 64'(1), 64'(trig_cnt - trig_base));
    check_records(name);
endtask

task automatic run_capture(string name, int n, int trig_at);
    prepare(n, trig_at);
    start_capture();
    drive_range(0, n - 1);
    finish_capture(name);
endtask

task automatic reset_defaults();
    check("reset tvalid", 64'(0), 64'(m_axis_tvalid));
    check("reset busy", 64'(0), 64'(sample_busy));
    check("reset done", 64'(0), 64'(sample_done));
    check("reset err", 64'(0), 64'(sample_err));
    check("reset trig_out", 64'(0), 64'(trig_out));
    check("reset pkt_info_wr", 64'(0), 64'(pkt_info_wr));
    check_records("reset");
endtask

task automatic config_validation();
    int errs;
    apply_config(64'h100, 64'h400, 8, 2);
    // pre above sample is refused so the old length of 8 stays
    apply_config(64'h100, 64'h400, 4, 6);
    run_capture("cfg_old_len", 12, 1);
    check("cfg_old_len length", 64'(8), 64'(got_data.size()));
    // address pair refused so 200 beats do not fit the ring
    apply_config(64'h500, 64'h400, 200, 2);
    errs = err_cnt;
    start_capture();
    check("cfg_err pulse", 64'(1), 64'(sample_err));
    @(posedge clk);
    #1;
    check("cfg_err busy", 64'(0), 64'(sample_busy));
    check("cfg_err count", 64'(errs + 1), 64'(err_cnt));
    repeat (4) begin
        check("cfg_err tvalid", 64'(0), 64'(m_axis_tvalid));
        @(posedge clk);
        #1;
    end
endtask

task automatic pretrigger_capture();
    apply_config(64'h0, 64'h10000, 16, 4);
    run_capture("pretrig", 24, 5);
    // six beats up to the trigger, then sample minus pre after it
    check("pretrig total beats", 64'(6 + 16 - 4), 64'(got_data.size()));
endtask

task automatic ring_packing();
    // three blocks of 64 bytes plus 24 bytes
    apply_config(64'h1000, 64'h10d8, 20, 4);
    run_capture("ring", 30, 11);
    check("ring wrap addr", 64'h1000, got_pkt_addr[got_pkt_addr.size() - 1]);
endtask

task automatic zero_pre_capture();
    apply_config(64'h2000, 64'h3000, 10, 0);
    run_capture("wait", 16, 5);
    check("wait first beat", stim_data[5], got_data[0]);
    check("wait trig equals start", exp_start_addr, rec_trig_addr);
endtask

task automatic backpressure_stall();
    apply_config(64'h4000, 64'h5000, 6, 2);
    prepare(6, 1);
    m_axis_tready = 1'b0;
    start_capture();
    drive_range(0, 0);
    repeat (8) begin
        check("stall tvalid", 64'(1), 64'(m_axis_tvalid));
        check("stall tdata", stim_data[0], m_axis_tdata);
        check("stall done", 64'(0), 64'(sample_done));
        check("stall pkt_info_wr", 64'(0), 64'(pkt_info_wr));
        @(posedge clk);
        #1;
    end
    m_axis_tready = 1'b1;
    drive_range(1, 5);
    finish_capture("stall");
endtask

`endif

// File: verification/tb_sample_core.sv
// testbench top for the capture core: clock, reset, DUT, monitor, watchdog, reference model, tests
`timescale 1ns/1ps
`default_nettype none

module tb_sample_core;

    import sample_pkg::*;

    localparam int BIT_WIDTH    = 64;
    localparam int BLOCK_SIZE   = 64;
    localparam int BEAT_BYTES   = BIT_WIDTH / 8;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int DONE_LIMIT   = 100;
    // rough cycle budget of reset plus the six tests
    localparam int TEST_CYCLES  = RESET_CYCLES + 60 + 40 + 50 + 40 + 40;
    localparam int TIMEOUT_NS   = (TEST_CYCLES + 300) * CLK_PERIOD;

    logic                  clk;
    logic                  rstn;
    addr_t                 config_start_addr;
    addr_t                 config_end_addr;
    count_t                config_sample_num;
    count_t                config_pre_sample_num;
    logic                  update_config;
    logic                  sample_start;
    logic                  sample_trig;
    logic [BIT_WIDTH-1:0]  data;
    logic                  data_valid;
    logic                  m_axis_tready;
    wire                   sample_busy;
    wire                   sample_done;
    wire                   sample_err;
    wire                   trig_out;
    wire                   m_axis_tvalid;
    wire [BIT_WIDTH-1:0]   m_axis_tdata;
    wire                   m_axis_tlast;
    wire                   pkt_info_wr;
    pkt_info_t             pkt_info_data;
    addr_t                 rec_trig_addr;
    addr_t                 rec_start_addr;
    addr_t                 rec_end_addr;

    // stimulus, expected and observed streams
    logic [63:0] stim_data[$];
    bit          stim_trig[$];
    logic [63:0] exp_data[$];
    bit          exp_last[$];
    logic [63:0] exp_pkt_addr[$];
    logic [63:0] exp_pkt_len[$];
    logic [63:0] got_data[$];
    bit          got_last[$];
    logic [63:0] got_pkt_addr[$];
    logic [63:0] got_pkt_len[$];
    logic [63:0] exp_trig_addr;
    logic [63:0] exp_end_addr;
    logic [63:0] exp_start_addr;

    // model copy of the active configuration
    logic [63:0] m_start;
    logic [63:0] m_end;
    int          m_sample;
    int          m_pre;

    int          done_cnt;
    int          err_cnt;
    int          trig_cnt;
    int          done_base;
    int          trig_base;
    int          fail_count;
    logic [31:0] lcg_state;

    sample_core #(
        .BIT_WIDTH  (BIT_WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) uut (
        .clk                   (clk),
        .rstn                  (rstn),
        .config_start_addr     (config_start_addr),
        .config_end_addr       (config_end_addr),
        .config_sample_num     (config_sample_num),
        .config_pre_sample_num (config_pre_sample_num),
        .update_config         (update_config),
        .sample_start          (sample_start),
        .sample_trig           (sample_trig),
        .data                  (data),
        .data_valid            (data_valid),
        .sample_busy           (sample_busy),
        .sample_done           (sample_done),
        .sample_err            (sample_err),
        .trig_out              (trig_out),
        .m_axis_tvalid         (m_axis_tvalid),
        .m_axis_tdata          (m_axis_tdata),
        .m_axis_tlast          (m_axis_tlast),
        .m_axis_tready         (m_axis_tready),
        .pkt_info_wr           (pkt_info_wr),
        .pkt_info_data         (pkt_info_data),
        .rec_trig_addr         (rec_trig_addr),
        .rec_start_addr        (rec_start_addr),
        .rec_end_addr          (rec_end_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ********************
    // stream and status monitor

    always @(posedge clk) begin
        if (rstn) begin
            if (m_axis_tvalid && m_axis_tready) begin
                got_data.push_back(m_axis_tdata);
                got_last.push_back(m_axis_tlast);
            end
            if (pkt_info_wr) begin
                got_pkt_addr.push_back(pkt_info_data.addr);
                got_pkt_len.push_back(64'(pkt_info_data.length));
            end
            if (sample_done) done_cnt++;
            if (sample_err) err_cnt++;
            if (trig_out) trig_cnt++;
        end
    end

    // ********************
    // reference model

    // step back from the final beat to the first beat of the window inside the ring
    function automatic logic [63:0] ring_back(logic [63:0] a);
        logic [63:0] span;
        span = 64'(m_sample - 1) * 64'(BEAT_BYTES);
        if (a - m_start >= span) begin
            return a - span;
        end
        return a + (m_end - m_start) - span;
    endfunction

    task automatic predict();
        int          cnt;
        int          post_left;
        int          trig_pos;
        int          bytes;
        bit          in_post;
        bit          done;
        bit          take;
        bit          trig;
        bit          fin;
        bit          last;
        logic [63:0] addr;
        logic [63:0] blk;
        logic [63:0] nxt;
        exp_data.delete();
        exp_last.delete();
        exp_pkt_addr.delete();
        exp_pkt_len.delete();
        cnt = 0;
        post_left = 0;
        bytes = 0;
        in_post = 0;
        done = 0;
        trig_pos = (m_pre == 0) ? 1 : m_pre;
        addr = m_start;
        blk = m_start;
        for (int i = 0; i < stim_data.size() && !done; i++) begin
            take = 0;
            trig = 0;
            fin = 0;
            if (!in_post) begin
                if (m_pre == 0) begin
                    take = stim_trig[i];
                    trig = stim_trig[i];
                end else begin
                    take = 1;
                    cnt++;
                    trig = stim_trig[i] && (cnt >= m_pre);
                end
                if (trig) begin
                    in_post = 1;
                    post_left = m_sample - trig_pos;
                    fin = (post_left == 0);
                end
            end else if (post_left > 0) begin
                take = 1;
                post_left--;
                fin = (post_left == 0);
            end
            if (take) begin
                nxt = addr + 64'(BEAT_BYTES);
                bytes += BEAT_BYTES;
                last = (bytes == BLOCK_SIZE) || (nxt >= m_end) || fin;
                exp_data.push_back(stim_data[i]);
                exp_last.push_back(last);
                if (trig) exp_trig_addr = addr;
                if (fin) begin
                    exp_end_addr = addr;
                    exp_start_addr = ring_back(addr);
                    done = 1;
                end
                if (last) begin
                    exp_pkt_addr.push_back(blk);
                    exp_pkt_len.push_back(64'(bytes));
                    blk = (nxt >= m_end) ? m_start : nxt;
                    bytes = 0;
                end
                addr = (nxt >= m_end) ? m_start : nxt;
            end
        end
    endtask

    `include "tb_tasks.svh"

    // ********************
    // watchdog

    initial begin
        #(TIMEOUT_NS);
        report_fail("watchdog expired before the tests finished");
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        config_start_addr = '0;
        config_end_addr = '0;
        config_sample_num = '0;
        config_pre_sample_num = '0;
        update_config = 1'b0;
        sample_start = 1'b0;
        sample_trig = 1'b0;
        data = '0;
        data_valid = 1'b0;
        m_axis_tready = 1'b1;
        done_cnt = 0;
        err_cnt = 0;
        trig_cnt = 0;
        fail_count = 0;
        lcg_state = 32'd90;
        m_start = DEFAULT_START_ADDR;
        m_end = DEFAULT_END_ADDR;
        m_sample = int'(DEFAULT_SAMPLE_NUM);
        m_pre = int'(DEFAULT_PRE_NUM);
        exp_trig_addr = '0;
        exp_end_addr = '0;
        exp_start_addr = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        reset_defaults();
        config_validation();
        pretrigger_capture();
        ring_packing();
        check_records("records_ring");
        zero_pre_capture();
        check_records("records_wait");
        backpressure_stall();
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sample_core.f
common/sample_pkg.sv
hdl/sample_config.sv
capture/capture_fsm.sv
capture/beat_register.sv
packer/block_packer.sv
packer/record_tracker.sv
hdl/sample_core.sv
+incdir+verification
verification/tb_sample_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the capture core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sample_core.f --top-module tb_sample_core -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1
